// ==== logic/dram_pkg.sv ====
package dram_pkg;

  // command and data widths seen by the clients
  localparam int ADDR_W = 32;
  localparam int DATA_W = 144;
  localparam int BE_W   = 18;                       // one enable per byte of DATA_W

  // command queue between arbiter and store
  localparam int QUEUE_DEPTH = 8;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // owner history for reads in flight
  // queue entries plus store and response path, so it never overflows
  localparam int HIST_DEPTH = 16;
  localparam int HIST_PTR_W = $clog2(HIST_DEPTH);

  // behavioral store, 64 words
  localparam int STORE_AW = 6;

  // packed queue entry {addr, rnw, wr_data, wr_be}
  localparam int CMD_W = ADDR_W + 1 + DATA_W + BE_W;

  // one-hot arbiter states
  localparam logic [2:0] ARB0     = 3'b001;      // client 0 granted
  localparam logic [2:0] ARB1     = 3'b010;      // client 1 granted
  localparam logic [2:0] ARB_WAIT = 3'b100;      // gap after a grant or back-pressure

endpackage

// ==== logic/read_history_fifo.sv ====
`timescale 1ns/1ps

module read_history_fifo (
  input  logic clk,
  input  logic rst,
  input  logic wr_data,
  input  logic wr_en,
  input  logic rd_en,
  output logic rd_data
);

  import dram_pkg::*;

  logic                  bits [HIST_DEPTH];
  logic [HIST_PTR_W-1:0] wr_ptr;
  logic [HIST_PTR_W-1:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      bits[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign rd_data = bits[rd_ptr];                  // show-ahead, oldest entry

endmodule

// ==== logic/dram_arbiter.sv ====
`timescale 1ns/1ps

module dram_arbiter (
  input  logic                        clk,
  input  logic                        rst,

  input  logic [dram_pkg::ADDR_W-1:0] client0_cmd_addr,
  input  logic                        client0_cmd_rnw,
  input  logic                        client0_cmd_valid,
  input  logic [dram_pkg::DATA_W-1:0] client0_wr_data,
  input  logic [dram_pkg::BE_W-1:0]   client0_wr_be,
  output logic [dram_pkg::DATA_W-1:0] client0_rd_data,
  output logic                        client0_rd_valid,
  output logic                        client0_ack,

  input  logic [dram_pkg::ADDR_W-1:0] client1_cmd_addr,
  input  logic                        client1_cmd_rnw,
  input  logic                        client1_cmd_valid,
  input  logic [dram_pkg::DATA_W-1:0] client1_wr_data,
  input  logic [dram_pkg::BE_W-1:0]   client1_wr_be,
  output logic [dram_pkg::DATA_W-1:0] client1_rd_data,
  output logic                        client1_rd_valid,
  output logic                        client1_ack,

  output logic [dram_pkg::ADDR_W-1:0] arb_cmd_addr,
  output logic                        arb_cmd_rnw,
  output logic                        arb_cmd_valid,
  output logic [dram_pkg::DATA_W-1:0] arb_wr_data,
  output logic [dram_pkg::BE_W-1:0]   arb_wr_be,
  input  logic                        queue_ready,
  input  logic [dram_pkg::DATA_W-1:0] mem_rd_data,
  input  logic                        mem_rd_valid
);

  import dram_pkg::*;

  logic [2:0] arb_state;
  logic       last_c1;                            // client 1 issued the last command
  logic       first_beat;                         // next mem_rd_valid is beat 0
  logic       hist_head;                          // owner of the oldest read, 1 = client 0
  logic       owner_q;                            // owner held for beat 1
  logic       hist_pop;
  logic       rd_to_c0;

  // grant machine
  always_ff @(posedge clk) begin
    if (rst) begin
      arb_state <= ARB0;
    end else begin
      unique case (arb_state)
        ARB0: begin
          if (!queue_ready || client0_cmd_valid) begin
            arb_state <= ARB_WAIT;
          end else if (client1_cmd_valid) begin
            arb_state <= ARB1;
          end
        end
        ARB1: begin
          if (!queue_ready || client1_cmd_valid) begin
            arb_state <= ARB_WAIT;
          end else if (client0_cmd_valid) begin
            arb_state <= ARB0;
          end
        end
        ARB_WAIT: begin
          if (queue_ready) begin
            case ({client1_cmd_valid, client0_cmd_valid})
              2'b10:   arb_state <= ARB1;
              2'b11:   arb_state <= last_c1 ? ARB0 : ARB1;   // the other client goes next
              default: arb_state <= ARB0;
            endcase
          end
        end
        default: arb_state <= ARB0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_c1 <= 1'b0;
    end else if (arb_cmd_valid) begin
      last_c1 <= client1_ack;
    end
  end

  assign client0_ack = (arb_state == ARB0);
  assign client1_ack = (arb_state == ARB1);

  // command mux, issued in the grant cycle
  assign arb_cmd_valid = (client0_ack && client0_cmd_valid) || (client1_ack && client1_cmd_valid);
  assign arb_cmd_addr  = client0_ack ? client0_cmd_addr : client1_cmd_addr;
  assign arb_cmd_rnw   = client0_ack ? client0_cmd_rnw  : client1_cmd_rnw;
  assign arb_wr_data   = client0_ack ? client0_wr_data  : client1_wr_data;
  assign arb_wr_be     = client0_ack ? client0_wr_be    : client1_wr_be;

  // responses come in pairs, toggle marks beat 0
  always_ff @(posedge clk) begin
    if (rst) begin
      first_beat <= 1'b1;
    end else if (mem_rd_valid) begin
      first_beat <= !first_beat;
    end
  end

  assign hist_pop = mem_rd_valid && first_beat;

  always_ff @(posedge clk) begin
    if (hist_pop) begin
      owner_q <= hist_head;                       // head moves on after the pop
    end
  end

  read_history_fifo u_history (
    .clk     (clk),
    .rst     (rst),
    .wr_data (client0_ack),
    .wr_en   (arb_cmd_valid && arb_cmd_rnw),      // only reads produce responses
    .rd_en   (hist_pop),
    .rd_data (hist_head)
  );

  assign rd_to_c0 = first_beat ? hist_head : owner_q;

  assign client0_rd_data  = mem_rd_data;
  assign client1_rd_data  = mem_rd_data;
  assign client0_rd_valid = mem_rd_valid && rd_to_c0;
  assign client1_rd_valid = mem_rd_valid && !rd_to_c0;

endmodule

// ==== logic/dram_cmd_queue.sv ====
`timescale 1ns/1ps

module dram_cmd_queue (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [dram_pkg::ADDR_W-1:0] push_addr,
  input  logic                        push_rnw,
  input  logic [dram_pkg::DATA_W-1:0] push_wr_data,
  input  logic [dram_pkg::BE_W-1:0]   push_wr_be,
  input  logic                        push,
  output logic                        ready,
  output logic [dram_pkg::ADDR_W-1:0] head_addr,
  output logic                        head_rnw,
  output logic [dram_pkg::DATA_W-1:0] head_wr_data,
  output logic [dram_pkg::BE_W-1:0]   head_wr_be,
  output logic                        head_valid,
  input  logic                        pop
);

  import dram_pkg::*;

  logic [CMD_W-1:0]       entries [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_PTR_W:0]   count;

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= {push_addr, push_rnw, push_wr_data, push_wr_be};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one slot kept for the command issued while ready falls
  assign ready      = (count <= QUEUE_DEPTH - 2);
  assign head_valid = (count != '0);

  assign {head_addr, head_rnw, head_wr_data, head_wr_be} = entries[rd_ptr];

endmodule

// ==== logic/dram_store.sv ====
`timescale 1ns/1ps

module dram_store (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [dram_pkg::ADDR_W-1:0] head_addr,
  input  logic                        head_rnw,
  input  logic [dram_pkg::DATA_W-1:0] head_wr_data,
  input  logic [dram_pkg::BE_W-1:0]   head_wr_be,
  input  logic                        head_valid,
  output logic                        pop,
  output logic [dram_pkg::DATA_W-1:0] rd_data,
  output logic                        rd_valid
);

  import dram_pkg::*;

  logic [DATA_W-1:0]   words [2**STORE_AW];
  logic [STORE_AW-1:0] idx;
  logic [STORE_AW-1:0] partner_idx;               // index with bit 0 inverted
  logic                beat0;
  logic                beat1;
  logic                idle;

  assign idx  = head_addr[STORE_AW-1:0];
  assign idle = !beat0 && !beat1;
  assign pop  = idle && head_valid;

  // write with byte enables, done in the pop cycle
  always_ff @(posedge clk) begin
    if (pop && !head_rnw) begin
      for (int i = 0; i < BE_W; i++) begin
        if (head_wr_be[i]) begin
          words[idx][8*i +: 8] <= head_wr_data[8*i +: 8];
        end
      end
    end
  end

  // two-beat read sequencer
  always_ff @(posedge clk) begin
    if (rst) begin
      beat0 <= 1'b0;
      beat1 <= 1'b0;
    end else begin
      beat0 <= pop && head_rnw;
      beat1 <= beat0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop && head_rnw) begin
      rd_data     <= words[idx];                  // addressed word first
      partner_idx <= {idx[STORE_AW-1:1], !idx[0]};
    end else if (beat0) begin
      rd_data     <= words[partner_idx];          // then its pair partner
    end
  end

  assign rd_valid = beat0 || beat1;

endmodule

// ==== logic/dram_port_sys.sv ====
`timescale 1ns/1ps

module dram_port_sys (
  input  logic                        clk,
  input  logic                        rst,

  input  logic [dram_pkg::ADDR_W-1:0] client0_cmd_addr,
  input  logic                        client0_cmd_rnw,
  input  logic                        client0_cmd_valid,
  input  logic [dram_pkg::DATA_W-1:0] client0_wr_data,
  input  logic [dram_pkg::BE_W-1:0]   client0_wr_be,
  output logic [dram_pkg::DATA_W-1:0] client0_rd_data,
  output logic                        client0_rd_valid,
  output logic                        client0_ack,

  input  logic [dram_pkg::ADDR_W-1:0] client1_cmd_addr,
  input  logic                        client1_cmd_rnw,
  input  logic                        client1_cmd_valid,
  input  logic [dram_pkg::DATA_W-1:0] client1_wr_data,
  input  logic [dram_pkg::BE_W-1:0]   client1_wr_be,
  output logic [dram_pkg::DATA_W-1:0] client1_rd_data,
  output logic                        client1_rd_valid,
  output logic                        client1_ack
);

  import dram_pkg::*;

  // arbiter to queue
  logic [ADDR_W-1:0] arb_cmd_addr;
  logic              arb_cmd_rnw;
  logic              arb_cmd_valid;
  logic [DATA_W-1:0] arb_wr_data;
  logic [BE_W-1:0]   arb_wr_be;
  logic              queue_ready;

  // queue to store
  logic [ADDR_W-1:0] head_addr;
  logic              head_rnw;
  logic [DATA_W-1:0] head_wr_data;
  logic [BE_W-1:0]   head_wr_be;
  logic              head_valid;
  logic              pop;

  // store back to arbiter
  logic [DATA_W-1:0] mem_rd_data;
  logic              mem_rd_valid;

  dram_arbiter u_arbiter (
    .clk               (clk),
    .rst               (rst),
    .client0_cmd_addr  (client0_cmd_addr),
    .client0_cmd_rnw   (client0_cmd_rnw),
    .client0_cmd_valid (client0_cmd_valid),
    .client0_wr_data   (client0_wr_data),
    .client0_wr_be     (client0_wr_be),
    .client0_rd_data   (client0_rd_data),
    .client0_rd_valid  (client0_rd_valid),
    .client0_ack       (client0_ack),
    .client1_cmd_addr  (client1_cmd_addr),
    .client1_cmd_rnw   (client1_cmd_rnw),
    .client1_cmd_valid (client1_cmd_valid),
    .client1_wr_data   (client1_wr_data),
    .client1_wr_be     (client1_wr_be),
    .client1_rd_data   (client1_rd_data),
    .client1_rd_valid  (client1_rd_valid),
    .client1_ack       (client1_ack),
    .arb_cmd_addr      (arb_cmd_addr),
    .arb_cmd_rnw       (arb_cmd_rnw),
    .arb_cmd_valid     (arb_cmd_valid),
    .arb_wr_data       (arb_wr_data),
    .arb_wr_be         (arb_wr_be),
    .queue_ready       (queue_ready),
    .mem_rd_data       (mem_rd_data),
    .mem_rd_valid      (mem_rd_valid)
  );

  dram_cmd_queue u_queue (
    .clk          (clk),
    .rst          (rst),
    .push_addr    (arb_cmd_addr),
    .push_rnw     (arb_cmd_rnw),
    .push_wr_data (arb_wr_data),
    .push_wr_be   (arb_wr_be),
    .push         (arb_cmd_valid),
    .ready        (queue_ready),
    .head_addr    (head_addr),
    .head_rnw     (head_rnw),
    .head_wr_data (head_wr_data),
    .head_wr_be   (head_wr_be),
    .head_valid   (head_valid),
    .pop          (pop)
  );

  dram_store u_store (
    .clk          (clk),
    .rst          (rst),
    .head_addr    (head_addr),
    .head_rnw     (head_rnw),
    .head_wr_data (head_wr_data),
    .head_wr_be   (head_wr_be),
    .head_valid   (head_valid),
    .pop          (pop),
    .rd_data      (mem_rd_data),
    .rd_valid     (mem_rd_valid)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;                              // 10 ns period
    end
  end

endmodule

// ==== tb/dram_port_sys_props.sv ====
`timescale 1ns/1ps

module dram_port_sys_props (
  input logic       clk,
  input logic       rst,
  input logic       client0_ack,
  input logic       client1_ack,
  input logic       client0_rd_valid,
  input logic       client1_rd_valid,
  input logic       first_beat,
  input logic       queue_ready,
  input logic       arb_cmd_valid,
  input logic [2:0] arb_state
);

  import dram_pkg::*;

  int ack_fails      = 0;
  int rd_valid_fails = 0;
  int wait_fails     = 0;

  // no grant while the queue holds commands back
  a_ack_needs_ready: assert property (@(posedge clk) disable iff (rst)
    (client0_ack || client1_ack) |-> queue_ready)
    else begin
      $error("client ack high while queue_ready low");
      ack_fails++;
    end

  // beat 1 follows beat 0 to the same client
  a_pair_same_client: assert property (@(posedge clk) disable iff (rst)
    (first_beat && (client0_rd_valid || client1_rd_valid)) |=>
      ({client1_rd_valid, client0_rd_valid} == $past({client1_rd_valid, client0_rd_valid})))
    else begin
      $error("second read beat missing or routed to the other client");
      rd_valid_fails++;
    end

  // every issue is followed by the gap state
  a_wait_after_issue: assert property (@(posedge clk) disable iff (rst)
    arb_cmd_valid |=> (arb_state == ARB_WAIT))
    else begin
      $error("arbiter not in ARB_WAIT after an issued command");
      wait_fails++;
    end

endmodule

// ==== tb/dram_port_sys_tb.sv ====
`timescale 1ns/1ps

module dram_port_sys_tb;

  import dram_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_FILL       = 2**STORE_AW;
  localparam int N_PAIR_READS = 8;                // reads per client in the shared test
  localparam int N_BURST      = 24;               // commands per client in the burst
  localparam int TOTAL_CMDS   = 3 + 4 + N_FILL + 2*N_PAIR_READS + 2*N_BURST;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] client0_cmd_addr;
  logic              client0_cmd_rnw;
  logic              client0_cmd_valid;
  logic [DATA_W-1:0] client0_wr_data;
  logic [BE_W-1:0]   client0_wr_be;
  logic [DATA_W-1:0] client0_rd_data;
  logic              client0_rd_valid;
  logic              client0_ack;
  logic [ADDR_W-1:0] client1_cmd_addr;
  logic              client1_cmd_rnw;
  logic              client1_cmd_valid;
  logic [DATA_W-1:0] client1_wr_data;
  logic [BE_W-1:0]   client1_wr_be;
  logic [DATA_W-1:0] client1_rd_data;
  logic              client1_rd_valid;
  logic              client1_ack;

  integer            seed = 32'ha32a;
  int                errors = 0;
  int                prop_fails = 0;
  int                ready_low_cycles = 0;
  int                grant_log [$];                // client id per accepted command
  logic [DATA_W-1:0] ref_mem [2**STORE_AW];
  logic [DATA_W-1:0] exp0 [$];
  logic [DATA_W-1:0] exp1 [$];
  logic [DATA_W-1:0] rcv0 [$];
  logic [DATA_W-1:0] rcv1 [$];

  tb_clk_gen u_clk (.clk(clk));

  dram_port_sys uut (
    .clk               (clk),
    .rst               (rst),
    .client0_cmd_addr  (client0_cmd_addr),
    .client0_cmd_rnw   (client0_cmd_rnw),
    .client0_cmd_valid (client0_cmd_valid),
    .client0_wr_data   (client0_wr_data),
    .client0_wr_be     (client0_wr_be),
    .client0_rd_data   (client0_rd_data),
    .client0_rd_valid  (client0_rd_valid),
    .client0_ack       (client0_ack),
    .client1_cmd_addr  (client1_cmd_addr),
    .client1_cmd_rnw   (client1_cmd_rnw),
    .client1_cmd_valid (client1_cmd_valid),
    .client1_wr_data   (client1_wr_data),
    .client1_wr_be     (client1_wr_be),
    .client1_rd_data   (client1_rd_data),
    .client1_rd_valid  (client1_rd_valid),
    .client1_ack       (client1_ack)
  );

  bind dram_arbiter dram_port_sys_props u_props (
    .clk              (clk),
    .rst              (rst),
    .client0_ack      (client0_ack),
    .client1_ack      (client1_ack),
    .client0_rd_valid (client0_rd_valid),
    .client1_rd_valid (client1_rd_valid),
    .first_beat       (first_beat),
    .queue_ready      (queue_ready),
    .arb_cmd_valid    (arb_cmd_valid),
    .arb_state        (arb_state)
  );

  // outputs are registered, so the falling edge sees settled values
  always @(negedge clk) begin
    if (!rst) begin
      if (client0_rd_valid) rcv0.push_back(client0_rd_data);
      if (client1_rd_valid) rcv1.push_back(client1_rd_data);
      if (!uut.queue_ready) ready_low_cycles++;
    end
  end

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    logic [31:0]       r;
    int                k;
    w = '0;
    for (k = 0; k < 5; k++) begin
      r = $random(seed);
      w = {w[DATA_W-33:0], r};
    end
    return w;
  endfunction

  function automatic logic [ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [BE_W-1:0] rand_be();
    logic [31:0] r;
    r = $random(seed);
    return r[BE_W-1:0];
  endfunction

  // holds the command until the grant edge, then updates the reference model
  task automatic drive_cmd(input int c, input logic [ADDR_W-1:0] addr, input logic rnw,
                           input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be);
    logic                granted;
    logic [STORE_AW-1:0] idx;
    logic [STORE_AW-1:0] pidx;
    int                  i;
    idx  = addr[STORE_AW-1:0];
    pidx = {idx[STORE_AW-1:1], ~idx[0]};
    if (c == 0) begin
      client0_cmd_addr  = addr;
      client0_cmd_rnw   = rnw;
      client0_wr_data   = data;
      client0_wr_be     = be;
      client0_cmd_valid = 1'b1;
    end else begin
      client1_cmd_addr  = addr;
      client1_cmd_rnw   = rnw;
      client1_wr_data   = data;
      client1_wr_be     = be;
      client1_cmd_valid = 1'b1;
    end
    granted = (c == 0) ? client0_ack : client1_ack;
    while (!granted) begin
      @(negedge clk);
      granted = (c == 0) ? client0_ack : client1_ack;
    end
    @(posedge clk);                               // accepted here
    grant_log.push_back(c);
    if (rnw) begin
      if (c == 0) begin
        exp0.push_back(ref_mem[idx]);
        exp0.push_back(ref_mem[pidx]);
      end else begin
        exp1.push_back(ref_mem[idx]);
        exp1.push_back(ref_mem[pidx]);
      end
    end else begin
      for (i = 0; i < BE_W; i++) begin
        if (be[i]) ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
    @(negedge clk);
    if (c == 0) client0_cmd_valid = 1'b0;
    else client1_cmd_valid = 1'b0;
  endtask

  task automatic compare_client(input int c);
    logic [DATA_W-1:0] got [$];
    logic [DATA_W-1:0] want [$];
    int                i;
    if (c == 0) begin
      got  = rcv0;
      want = exp0;
    end else begin
      got  = rcv1;
      want = exp1;
    end
    assert (got.size() == want.size()) else begin
      $display("** Error: client%0d_rd_valid beats = %h, expected %h", c, got.size(),
               want.size());
      errors++;
    end
    for (i = 0; i < want.size() && i < got.size(); i++) begin
      assert (got[i] == want[i]) else begin
        $display("** Error: client%0d_rd_data beat %0d = %h, expected %h", c, i, got[i],
                 want[i]);
        errors++;
      end
    end
  endtask

  task automatic check_responses();
    while (rcv0.size() < exp0.size() || rcv1.size() < exp1.size()) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);                    // room for stray beats
    compare_client(0);
    compare_client(1);
    exp0.delete();
    exp1.delete();
    rcv0.delete();
    rcv1.delete();
  endtask

  task automatic check_reset_state();
    assert (client0_ack == 1'b1) else begin
      $display("** Error: client0_ack = %h, expected %h", client0_ack, 1'b1);
      errors++;
    end
    assert (client1_ack == 1'b0) else begin
      $display("** Error: client1_ack = %h, expected %h", client1_ack, 1'b0);
      errors++;
    end
    repeat (20) begin
      @(negedge clk);
      assert (!client0_rd_valid && !client1_rd_valid) else begin
        $display("** Error: {client1_rd_valid, client0_rd_valid} = %h, expected %h",
                 {client1_rd_valid, client0_rd_valid}, 2'b00);
        errors++;
      end
    end
  endtask

  task automatic write_pair_read_even();
    logic [ADDR_W-1:0] base;
    base    = rand_addr();
    base[0] = 1'b0;
    drive_cmd(0, base, 1'b0, rand_word(), '1);
    drive_cmd(0, {base[ADDR_W-1:1], 1'b1}, 1'b0, rand_word(), '1);
    drive_cmd(0, base, 1'b1, '0, '0);
    check_responses();
  endtask

  task automatic partial_write_merge();
    logic [ADDR_W-1:0] a;
    logic [BE_W-1:0]   mask;
    a       = rand_addr();
    mask    = rand_be();
    mask[0] = 1'b1;                               // at least one new and one old byte
    mask[1] = 1'b0;
    drive_cmd(1, a, 1'b0, rand_word(), '1);
    drive_cmd(1, {a[ADDR_W-1:1], ~a[0]}, 1'b0, rand_word(), '1);
    drive_cmd(1, a, 1'b0, rand_word(), mask);
    drive_cmd(1, a, 1'b1, '0, '0);
    check_responses();
  endtask

  task automatic fill_store();
    int i;
    for (i = 0; i < N_FILL; i++) begin
      drive_cmd(1, ADDR_W'(i), 1'b0, rand_word(), '1);
    end
  endtask

  task automatic shared_reads();
    int i;
    int j;
    grant_log.delete();
    fork
      begin
        for (i = 0; i < N_PAIR_READS; i++) drive_cmd(0, rand_addr(), 1'b1, '0, '0);
      end
      begin
        for (j = 0; j < N_PAIR_READS; j++) drive_cmd(1, rand_addr(), 1'b1, '0, '0);
      end
    join
    for (i = 1; i < grant_log.size(); i++) begin
      assert (grant_log[i] != grant_log[i-1]) else begin
        $display("** Error: grant_log[%0d] = %h, expected %h", i, grant_log[i],
                 1 - grant_log[i-1]);
        errors++;
      end
    end
    check_responses();
  endtask

  task automatic mixed_burst();
    int i;
    int j;
    int low_before;
    low_before = ready_low_cycles;
    fork
      begin
        for (i = 0; i < N_BURST; i++) begin
          drive_cmd(0, rand_addr(), (i % 4) != 3, rand_word(), rand_be());
        end
      end
      begin
        for (j = 0; j < N_BURST; j++) begin
          drive_cmd(1, rand_addr(), (j % 4) != 3, rand_word(), rand_be());
        end
      end
    join
    check_responses();
    assert (ready_low_cycles > low_before) else begin
      $display("queue_ready never dropped during the burst, back-pressure was not exercised");
      errors++;
    end
  endtask

  initial begin
    rst               = 1'b1;
    client0_cmd_addr  = '0;
    client0_cmd_rnw   = 1'b0;
    client0_cmd_valid = 1'b0;
    client0_wr_data   = '0;
    client0_wr_be     = '0;
    client1_cmd_addr  = '0;
    client1_cmd_rnw   = 1'b0;
    client1_cmd_valid = 1'b0;
    client1_wr_data   = '0;
    client1_wr_be     = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    write_pair_read_even();
    partial_write_merge();
    fill_store();
    shared_reads();
    mixed_burst();
    prop_fails = uut.u_arbiter.u_props.ack_fails + uut.u_arbiter.u_props.rd_valid_fails
               + uut.u_arbiter.u_props.wait_fails;
    $display("summary: %0d check errors, %0d assertion failures", errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog, 20 cycles per command plus reset
  initial begin
    repeat (TOTAL_CMDS * 20 + RESET_CYCLES) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("summary: %0d check errors before the timeout", errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== dram_port_sys.f ====
logic/dram_pkg.sv
logic/read_history_fifo.sv
logic/dram_arbiter.sv
logic/dram_cmd_queue.sv
logic/dram_store.sv
logic/dram_port_sys.sv
tb/tb_clk_gen.sv
tb/dram_port_sys_props.sv
tb/dram_port_sys_tb.sv

// ==== Makefile ====
# Verilator flow for the shared DRAM port subsystem

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP       = dram_port_sys_tb
RTL_TOP   = dram_port_sys
FILELIST  = dram_port_sys.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the pipeline status is the grep status, so a missing pass line fails the target
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
